//--- logic/rv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv_pkg
// shared RV64 widths, field types, opcode
// constants and decoded operation codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] data_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [11:0]     imm12_t;
  typedef logic [2:0]      funct3_t;

  // opcode[6:2], opcode[1:0] must be 2'b11
  localparam logic [4:0] OPC_LOAD     = 5'b00000;
  localparam logic [4:0] OPC_STORE    = 5'b01000;
  localparam logic [4:0] OPC_BRANCH   = 5'b11000;
  localparam logic [4:0] OPC_OP       = 5'b01100;
  localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
  localparam logic [4:0] OPC_OP_W     = 5'b01110;
  localparam logic [4:0] OPC_OP_IMM_W = 5'b00110;
  localparam logic [4:0] OPC_LUI      = 5'b01101;
  localparam logic [4:0] OPC_AUIPC    = 5'b00101;
  localparam logic [4:0] OPC_JAL      = 5'b11011;
  localparam logic [4:0] OPC_JALR     = 5'b11001;

  typedef enum logic [7:0] {
    OP_NONE = 8'd0,
    // register-register
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    // register-immediate
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
    OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
    // 32-bit word forms
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    // multiply and divide
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW,
    // branches
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    // memory
    OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
    OP_SB, OP_SH, OP_SW, OP_SD,
    // upper immediates and jumps
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR
  } op_e;

endpackage

`default_nettype wire

//--- logic/inst_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// inst_decoder
// RV64IM decode: operation, register use,
// operand alternates and memory fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
  input  wire logic              valid_i,
  input  wire rv_pkg::inst_t     inst_i,
  input  wire rv_pkg::data_t     pc_i,
  output rv_pkg::op_e            op_o,
  output logic                   rs1_re_o,
  output logic                   rs2_re_o,
  output rv_pkg::reg_addr_t      rs1_addr_o,
  output rv_pkg::reg_addr_t      rs2_addr_o,
  output rv_pkg::reg_addr_t      rd_addr_o,
  output logic                   rd_we_o,
  output rv_pkg::data_t          op1_alt_o,
  output rv_pkg::data_t          op2_alt_o,
  output rv_pkg::imm12_t         mem_off_o,
  output rv_pkg::funct3_t        mem_size_o
);

  logic [4:0]        opc;
  rv_pkg::funct3_t   funct3;
  logic              f7_m;
  logic              f7_alt;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  logic [11:0]       i_imm;
  logic [11:0]       s_imm;
  logic [19:0]       u_imm;
  logic              legal;

  assign opc    = inst_i[6:2];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1    = inst_i[19:15];
  assign rs2    = inst_i[24:20];
  // funct7 bit 0 selects M ops, bit 5 sub/sra
  assign f7_m   = inst_i[25];
  assign f7_alt = inst_i[30];
  assign i_imm  = inst_i[31:20];
  assign s_imm  = {inst_i[31:25], inst_i[11:7]};
  assign u_imm  = inst_i[31:12];

  always_comb begin
    op_o = rv_pkg::OP_NONE;
    if (valid_i && inst_i[1:0] == 2'b11) begin
      case (opc)
        rv_pkg::OPC_LOAD: begin
          case (funct3)
            3'b000:  op_o = rv_pkg::OP_LB;
            3'b001:  op_o = rv_pkg::OP_LH;
            3'b010:  op_o = rv_pkg::OP_LW;
            3'b011:  op_o = rv_pkg::OP_LD;
            3'b100:  op_o = rv_pkg::OP_LBU;
            3'b101:  op_o = rv_pkg::OP_LHU;
            3'b110:  op_o = rv_pkg::OP_LWU;
            default: op_o = rv_pkg::OP_NONE;
          endcase
        end
        rv_pkg::OPC_STORE: begin
          case (funct3)
            3'b000:  op_o = rv_pkg::OP_SB;
            3'b001:  op_o = rv_pkg::OP_SH;
            3'b010:  op_o = rv_pkg::OP_SW;
            3'b011:  op_o = rv_pkg::OP_SD;
            default: op_o = rv_pkg::OP_NONE;
          endcase
        end
        rv_pkg::OPC_BRANCH: begin
          case (funct3)
            3'b000:  op_o = rv_pkg::OP_BEQ;
            3'b001:  op_o = rv_pkg::OP_BNE;
            3'b100:  op_o = rv_pkg::OP_BLT;
            3'b101:  op_o = rv_pkg::OP_BGE;
            3'b110:  op_o = rv_pkg::OP_BLTU;
            3'b111:  op_o = rv_pkg::OP_BGEU;
            default: op_o = rv_pkg::OP_NONE;
          endcase
        end
        rv_pkg::OPC_OP: begin
          case ({f7_alt, f7_m, funct3})
            5'b00_000: op_o = rv_pkg::OP_ADD;
            5'b00_001: op_o = rv_pkg::OP_SLL;
            5'b00_010: op_o = rv_pkg::OP_SLT;
            5'b00_011: op_o = rv_pkg::OP_SLTU;
            5'b00_100: op_o = rv_pkg::OP_XOR;
            5'b00_101: op_o = rv_pkg::OP_SRL;
            5'b00_110: op_o = rv_pkg::OP_OR;
            5'b00_111: op_o = rv_pkg::OP_AND;
            5'b10_000: op_o = rv_pkg::OP_SUB;
            5'b10_101: op_o = rv_pkg::OP_SRA;
            5'b01_000: op_o = rv_pkg::OP_MUL;
            5'b01_001: op_o = rv_pkg::OP_MULH;
            5'b01_010: op_o = rv_pkg::OP_MULHSU;
            5'b01_011: op_o = rv_pkg::OP_MULHU;
            5'b01_100: op_o = rv_pkg::OP_DIV;
            5'b01_101: op_o = rv_pkg::OP_DIVU;
            5'b01_110: op_o = rv_pkg::OP_REM;
            5'b01_111: op_o = rv_pkg::OP_REMU;
            default:   op_o = rv_pkg::OP_NONE;
          endcase
        end
        rv_pkg::OPC_OP_W: begin
          case ({f7_alt, f7_m, funct3})
            5'b00_000: op_o = rv_pkg::OP_ADDW;
            5'b00_001: op_o = rv_pkg::OP_SLLW;
            5'b00_101: op_o = rv_pkg::OP_SRLW;
            5'b10_000: op_o = rv_pkg::OP_SUBW;
            5'b10_101: op_o = rv_pkg::OP_SRAW;
            5'b01_000: op_o = rv_pkg::OP_MULW;
            5'b01_100: op_o = rv_pkg::OP_DIVW;
            5'b01_101: op_o = rv_pkg::OP_DIVUW;
            5'b01_110: op_o = rv_pkg::OP_REMW;
            5'b01_111: op_o = rv_pkg::OP_REMUW;
            default:   op_o = rv_pkg::OP_NONE;
          endcase
        end
        rv_pkg::OPC_OP_IMM: begin
          // bit 25 is shamt[5] here, so only bit 30 counts
          case (funct3)
            3'b000:  op_o = rv_pkg::OP_ADDI;
            3'b010:  op_o = rv_pkg::OP_SLTI;
            3'b011:  op_o = rv_pkg::OP_SLTIU;
            3'b100:  op_o = rv_pkg::OP_XORI;
            3'b110:  op_o = rv_pkg::OP_ORI;
            3'b111:  op_o = rv_pkg::OP_ANDI;
            3'b001:  op_o = f7_alt ? rv_pkg::OP_NONE : rv_pkg::OP_SLLI;
            default: op_o = f7_alt ? rv_pkg::OP_SRAI : rv_pkg::OP_SRLI;
          endcase
        end
        rv_pkg::OPC_OP_IMM_W: begin
          casez ({f7_alt, f7_m, funct3})
            5'b??_000: op_o = rv_pkg::OP_ADDIW;
            5'b00_001: op_o = rv_pkg::OP_SLLIW;
            5'b00_101: op_o = rv_pkg::OP_SRLIW;
            5'b10_101: op_o = rv_pkg::OP_SRAIW;
            default:   op_o = rv_pkg::OP_NONE;
          endcase
        end
        rv_pkg::OPC_LUI:   op_o = rv_pkg::OP_LUI;
        rv_pkg::OPC_AUIPC: op_o = rv_pkg::OP_AUIPC;
        rv_pkg::OPC_JAL:   op_o = rv_pkg::OP_JAL;
        rv_pkg::OPC_JALR:  op_o = (funct3 == 3'b000) ? rv_pkg::OP_JALR : rv_pkg::OP_NONE;
        default:           op_o = rv_pkg::OP_NONE;
      endcase
    end
  end

  // anything unrecognized stays OP_NONE and touches no register
  assign legal = (op_o != rv_pkg::OP_NONE);

  assign rs1_re_o = legal && !(opc == rv_pkg::OPC_LUI || opc == rv_pkg::OPC_AUIPC ||
                               opc == rv_pkg::OPC_JAL);
  assign rs2_re_o = legal && (opc == rv_pkg::OPC_OP || opc == rv_pkg::OPC_OP_W ||
                              opc == rv_pkg::OPC_BRANCH || opc == rv_pkg::OPC_STORE);
  assign rd_we_o  = legal && (rd != '0) &&
                    !(opc == rv_pkg::OPC_BRANCH || opc == rv_pkg::OPC_STORE);

  assign rs1_addr_o = rs1_re_o ? rs1 : '0;
  assign rs2_addr_o = rs2_re_o ? rs2 : '0;
  assign rd_addr_o  = rd_we_o ? rd : '0;

  assign op1_alt_o = (legal && (opc == rv_pkg::OPC_AUIPC || opc == rv_pkg::OPC_JAL)) ?
                     pc_i : '0;

  always_comb begin
    op2_alt_o = '0;
    if (legal) begin
      if (opc == rv_pkg::OPC_OP_IMM || opc == rv_pkg::OPC_OP_IMM_W) begin
        op2_alt_o = {{(rv_pkg::XLEN-12){i_imm[11]}}, i_imm};
      end else if (opc == rv_pkg::OPC_LUI || opc == rv_pkg::OPC_AUIPC) begin
        // raw U field, execute does the shift
        op2_alt_o = {{(rv_pkg::XLEN-20){u_imm[19]}}, u_imm};
      end else if (opc == rv_pkg::OPC_JAL || opc == rv_pkg::OPC_JALR) begin
        op2_alt_o = pc_i;
      end
    end
  end

  assign mem_off_o  = (legal && opc == rv_pkg::OPC_LOAD)  ? i_imm :
                      (legal && opc == rv_pkg::OPC_STORE) ? s_imm : '0;
  assign mem_size_o = (legal && (opc == rv_pkg::OPC_LOAD || opc == rv_pkg::OPC_STORE)) ?
                      funct3 : '0;

  always_comb begin
    assert final (!rd_we_o || rd_addr_o != '0)
      else $error("write enable raised for x0");
  end

endmodule

`default_nettype wire

//--- logic/operand_bypass.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand_bypass
// operand forwarding from ex and mem,
// plus load-use stall detection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module operand_bypass (
  input  wire logic              rs1_re_i,
  input  wire logic              rs2_re_i,
  input  wire rv_pkg::reg_addr_t rs1_addr_i,
  input  wire rv_pkg::reg_addr_t rs2_addr_i,
  input  wire rv_pkg::data_t     rs1_data_i,
  input  wire rv_pkg::data_t     rs2_data_i,
  input  wire rv_pkg::data_t     op1_alt_i,
  input  wire rv_pkg::data_t     op2_alt_i,
  input  wire logic              ex_rd_we_i,
  input  wire rv_pkg::reg_addr_t ex_rd_addr_i,
  input  wire rv_pkg::data_t     ex_rd_data_i,
  input  wire logic              ex_is_load_i,
  input  wire logic              mem_rd_we_i,
  input  wire rv_pkg::reg_addr_t mem_rd_addr_i,
  input  wire rv_pkg::data_t     mem_rd_data_i,
  output rv_pkg::data_t          op1_o,
  output rv_pkg::data_t          op2_o,
  output logic                   stall_o
);

  logic load_dep1;
  logic load_dep2;

  // youngest producer wins: ex, then mem, then regfile
  function automatic rv_pkg::data_t pick_operand(
    input logic              re,
    input rv_pkg::reg_addr_t addr,
    input rv_pkg::data_t     rf_data,
    input rv_pkg::data_t     alt
  );
    rv_pkg::data_t val;
    if (!re) begin
      val = alt;
    end else if (ex_rd_we_i && ex_rd_addr_i == addr) begin
      val = ex_rd_data_i;
    end else if (mem_rd_we_i && mem_rd_addr_i == addr) begin
      val = mem_rd_data_i;
    end else begin
      val = rf_data;
    end
    return val;
  endfunction

  always_comb begin
    op1_o = pick_operand(rs1_re_i, rs1_addr_i, rs1_data_i, op1_alt_i);
    op2_o = pick_operand(rs2_re_i, rs2_addr_i, rs2_data_i, op2_alt_i);
  end

  // load result not ready until mem, so ex forwarding is too early
  assign load_dep1 = ex_is_load_i && rs1_re_i && (rs1_addr_i == ex_rd_addr_i);
  assign load_dep2 = ex_is_load_i && rs2_re_i && (rs2_addr_i == ex_rd_addr_i);
  assign stall_o   = load_dep1 || load_dep2;

  always_comb begin
    assert final (!stall_o || rs1_re_i || rs2_re_i)
      else $error("stall without any register read");
  end

endmodule

`default_nettype wire

//--- logic/id_ex_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// id_ex_reg
// id/ex pipeline register, bubble on
// stall, invalid input or reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg (
  input  wire logic              clk,
  input  wire logic              rst_i,
  input  wire logic              valid_i,
  input  wire logic              stall_i,
  input  wire rv_pkg::op_e       op_i,
  input  wire rv_pkg::data_t     op1_i,
  input  wire rv_pkg::data_t     op2_i,
  input  wire rv_pkg::data_t     pc_i,
  input  wire logic              rd_we_i,
  input  wire rv_pkg::reg_addr_t rd_addr_i,
  input  wire rv_pkg::imm12_t    mem_off_i,
  input  wire rv_pkg::funct3_t   mem_size_i,
  output logic                   ex_valid_o,
  output rv_pkg::op_e            ex_op_o,
  output rv_pkg::data_t          ex_op1_o,
  output rv_pkg::data_t          ex_op2_o,
  output rv_pkg::data_t          ex_pc_o,
  output logic                   ex_rd_we_o,
  output rv_pkg::reg_addr_t      ex_rd_addr_o,
  output rv_pkg::imm12_t         ex_mem_off_o,
  output rv_pkg::funct3_t        ex_mem_size_o
);

  always_ff @(posedge clk) begin
    if (rst_i || stall_i || !valid_i) begin
      // bubble, fetch holds the stalled word for redecode
      ex_valid_o    <= 1'b0;
      ex_op_o       <= rv_pkg::OP_NONE;
      ex_op1_o      <= '0;
      ex_op2_o      <= '0;
      ex_pc_o       <= '0;
      ex_rd_we_o    <= 1'b0;
      ex_rd_addr_o  <= '0;
      ex_mem_off_o  <= '0;
      ex_mem_size_o <= '0;
    end else begin
      ex_valid_o    <= 1'b1;
      ex_op_o       <= op_i;
      ex_op1_o      <= op1_i;
      ex_op2_o      <= op2_i;
      ex_pc_o       <= pc_i;
      ex_rd_we_o    <= rd_we_i;
      ex_rd_addr_o  <= rd_addr_i;
      ex_mem_off_o  <= mem_off_i;
      ex_mem_size_o <= mem_size_i;
    end
  end

  assert property (@(posedge clk) disable iff (rst_i) ex_rd_we_o |-> ex_valid_o)
    else $error("ex write enable on a bubble");

endmodule

`default_nettype wire

//--- logic/id_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// id_stage
// decode stage: decoder, operand bypass
// and the registered hand-off to execute
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module id_stage (
  input  wire logic              clk,
  input  wire logic              rst_i,
  // fetch
  input  wire logic              valid_i,
  input  wire rv_pkg::inst_t     inst_i,
  input  wire rv_pkg::data_t     pc_i,
  // register file
  output rv_pkg::reg_addr_t      rs1_addr_o,
  output rv_pkg::reg_addr_t      rs2_addr_o,
  input  wire rv_pkg::data_t     rs1_data_i,
  input  wire rv_pkg::data_t     rs2_data_i,
  // forwarding
  input  wire logic              ex_rd_we_i,
  input  wire rv_pkg::reg_addr_t ex_rd_addr_i,
  input  wire rv_pkg::data_t     ex_rd_data_i,
  input  wire logic              ex_is_load_i,
  input  wire logic              mem_rd_we_i,
  input  wire rv_pkg::reg_addr_t mem_rd_addr_i,
  input  wire rv_pkg::data_t     mem_rd_data_i,
  output logic                   stall_o,
  // to execute
  output logic                   ex_valid_o,
  output rv_pkg::op_e            ex_op_o,
  output rv_pkg::data_t          ex_op1_o,
  output rv_pkg::data_t          ex_op2_o,
  output rv_pkg::data_t          ex_pc_o,
  output logic                   ex_rd_we_o,
  output rv_pkg::reg_addr_t      ex_rd_addr_o,
  output rv_pkg::imm12_t         ex_mem_off_o,
  output rv_pkg::funct3_t        ex_mem_size_o
);

  rv_pkg::op_e       dec_op;
  logic              rs1_re;
  logic              rs2_re;
  rv_pkg::reg_addr_t rd_addr;
  logic              rd_we;
  rv_pkg::data_t     op1_alt;
  rv_pkg::data_t     op2_alt;
  rv_pkg::imm12_t    mem_off;
  rv_pkg::funct3_t   mem_size;
  rv_pkg::data_t     op1;
  rv_pkg::data_t     op2;

  inst_decoder u_decoder (
    .valid_i    (valid_i),
    .inst_i     (inst_i),
    .pc_i       (pc_i),
    .op_o       (dec_op),
    .rs1_re_o   (rs1_re),
    .rs2_re_o   (rs2_re),
    .rs1_addr_o (rs1_addr_o),
    .rs2_addr_o (rs2_addr_o),
    .rd_addr_o  (rd_addr),
    .rd_we_o    (rd_we),
    .op1_alt_o  (op1_alt),
    .op2_alt_o  (op2_alt),
    .mem_off_o  (mem_off),
    .mem_size_o (mem_size)
  );

  operand_bypass u_bypass (
    .rs1_re_i      (rs1_re),
    .rs2_re_i      (rs2_re),
    .rs1_addr_i    (rs1_addr_o),
    .rs2_addr_i    (rs2_addr_o),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .op1_alt_i     (op1_alt),
    .op2_alt_i     (op2_alt),
    .ex_rd_we_i    (ex_rd_we_i),
    .ex_rd_addr_i  (ex_rd_addr_i),
    .ex_rd_data_i  (ex_rd_data_i),
    .ex_is_load_i  (ex_is_load_i),
    .mem_rd_we_i   (mem_rd_we_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .mem_rd_data_i (mem_rd_data_i),
    .op1_o         (op1),
    .op2_o         (op2),
    .stall_o       (stall_o)
  );

  id_ex_reg u_id_ex (
    .clk           (clk),
    .rst_i         (rst_i),
    .valid_i       (valid_i),
    .stall_i       (stall_o),
    .op_i          (dec_op),
    .op1_i         (op1),
    .op2_i         (op2),
    .pc_i          (pc_i),
    .rd_we_i       (rd_we),
    .rd_addr_i     (rd_addr),
    .mem_off_i     (mem_off),
    .mem_size_i    (mem_size),
    .ex_valid_o    (ex_valid_o),
    .ex_op_o       (ex_op_o),
    .ex_op1_o      (ex_op1_o),
    .ex_op2_o      (ex_op2_o),
    .ex_pc_o       (ex_pc_o),
    .ex_rd_we_o    (ex_rd_we_o),
    .ex_rd_addr_o  (ex_rd_addr_o),
    .ex_mem_off_o  (ex_mem_off_o),
    .ex_mem_size_o (ex_mem_size_o)
  );

endmodule

`default_nettype wire

//--- bench/id_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// id stage reference model
// xorshift source, instruction builder and
// expected decode of each built word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

logic [31:0] rng_state = 32'd36511;

// expected decode of the last built word
rv_pkg::op_e       m_op;
logic              m_rs1_re;
logic              m_rs2_re;
logic              m_rd_we;
rv_pkg::reg_addr_t m_rs1;
rv_pkg::reg_addr_t m_rs2;
rv_pkg::reg_addr_t m_rd;
rv_pkg::data_t     m_op1_alt;
rv_pkg::data_t     m_op2_alt;
rv_pkg::imm12_t    m_mem_off;
rv_pkg::funct3_t   m_mem_size;

// class index 0..10, index 11 is an illegal word
localparam logic [4:0] CLASS_OPC [11] = '{
  rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH, rv_pkg::OPC_OP,
  rv_pkg::OPC_OP_W, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP_IMM_W, rv_pkg::OPC_LUI,
  rv_pkg::OPC_AUIPC, rv_pkg::OPC_JAL, rv_pkg::OPC_JALR
};

// rows indexed by funct3, per class and funct7 variant
localparam rv_pkg::op_e OP_ROWS [14][8] = '{
  '{rv_pkg::OP_LB, rv_pkg::OP_LH, rv_pkg::OP_LW, rv_pkg::OP_LD,
    rv_pkg::OP_LBU, rv_pkg::OP_LHU, rv_pkg::OP_LWU, rv_pkg::OP_NONE},
  '{rv_pkg::OP_SB, rv_pkg::OP_SH, rv_pkg::OP_SW, rv_pkg::OP_SD,
    rv_pkg::OP_NONE, rv_pkg::OP_NONE, rv_pkg::OP_NONE, rv_pkg::OP_NONE},
  '{rv_pkg::OP_BEQ, rv_pkg::OP_BNE, rv_pkg::OP_NONE, rv_pkg::OP_NONE,
    rv_pkg::OP_BLT, rv_pkg::OP_BGE, rv_pkg::OP_BLTU, rv_pkg::OP_BGEU},
  '{rv_pkg::OP_ADD, rv_pkg::OP_SLL, rv_pkg::OP_SLT, rv_pkg::OP_SLTU,
    rv_pkg::OP_XOR, rv_pkg::OP_SRL, rv_pkg::OP_OR, rv_pkg::OP_AND},
  '{rv_pkg::OP_SUB, rv_pkg::OP_NONE, rv_pkg::OP_NONE, rv_pkg::OP_NONE,
    rv_pkg::OP_NONE, rv_pkg::OP_SRA, rv_pkg::OP_NONE, rv_pkg::OP_NONE},
  '{rv_pkg::OP_MUL, rv_pkg::OP_MULH, rv_pkg::OP_MULHSU, rv_pkg::OP_MULHU,
    rv_pkg::OP_DIV, rv_pkg::OP_DIVU, rv_pkg::OP_REM, rv_pkg::OP_REMU},
  '{rv_pkg::OP_ADDW, rv_pkg::OP_SLLW, rv_pkg::OP_NONE, rv_pkg::OP_NONE,
    rv_pkg::OP_NONE, rv_pkg::OP_SRLW, rv_pkg::OP_NONE, rv_pkg::OP_NONE},
  '{rv_pkg::OP_SUBW, rv_pkg::OP_NONE, rv_pkg::OP_NONE, rv_pkg::OP_NONE,
    rv_pkg::OP_NONE, rv_pkg::OP_SRAW, rv_pkg::OP_NONE, rv_pkg::OP_NONE},
  '{rv_pkg::OP_MULW, rv_pkg::OP_NONE, rv_pkg::OP_NONE, rv_pkg::OP_NONE,
    rv_pkg::OP_DIVW, rv_pkg::OP_DIVUW, rv_pkg::OP_REMW, rv_pkg::OP_REMUW},
  '{rv_pkg::OP_ADDI, rv_pkg::OP_SLLI, rv_pkg::OP_SLTI, rv_pkg::OP_SLTIU,
    rv_pkg::OP_XORI, rv_pkg::OP_SRLI, rv_pkg::OP_ORI, rv_pkg::OP_ANDI},
  '{rv_pkg::OP_ADDI, rv_pkg::OP_NONE, rv_pkg::OP_SLTI, rv_pkg::OP_SLTIU,
    rv_pkg::OP_XORI, rv_pkg::OP_SRAI, rv_pkg::OP_ORI, rv_pkg::OP_ANDI},
  '{rv_pkg::OP_ADDIW, rv_pkg::OP_SLLIW, rv_pkg::OP_NONE, rv_pkg::OP_NONE,
    rv_pkg::OP_NONE, rv_pkg::OP_SRLIW, rv_pkg::OP_NONE, rv_pkg::OP_NONE},
  '{rv_pkg::OP_ADDIW, rv_pkg::OP_NONE, rv_pkg::OP_NONE, rv_pkg::OP_NONE,
    rv_pkg::OP_NONE, rv_pkg::OP_SRAIW, rv_pkg::OP_NONE, rv_pkg::OP_NONE},
  '{rv_pkg::OP_ADDIW, rv_pkg::OP_NONE, rv_pkg::OP_NONE, rv_pkg::OP_NONE,
    rv_pkg::OP_NONE, rv_pkg::OP_NONE, rv_pkg::OP_NONE, rv_pkg::OP_NONE}
};

function automatic logic [31:0] xorshift32();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

task automatic build_inst(input rv_pkg::data_t pc, output rv_pkg::inst_t inst);
  int         cls;
  int         v;
  logic [2:0] f3;
  logic       legal;
  cls  = int'(xorshift32() % 32'd12);
  v    = int'(xorshift32() % 32'd3);
  inst = xorshift32();
  // jalr mostly with its only legal funct3
  if (cls == 10 && v != 0) begin
    inst[14:12] = 3'b000;
  end
  f3 = inst[14:12];
  m_op = rv_pkg::OP_NONE;
  if (cls == 11) begin
    inst[1:0] = 2'b01;
  end else begin
    inst[6:0] = {CLASS_OPC[cls], 2'b11};
    // funct7 variant: base, alternate (bit 30) or M (bit 25)
    if (cls == 3 || cls == 4 || ((cls == 5 || cls == 6) && f3[1:0] == 2'b01)) begin
      inst[31:25] = (v == 0) ? 7'h00 : (v == 1) ? 7'h20 : 7'h01;
    end
    case (cls)
      0, 1, 2: m_op = OP_ROWS[cls][f3];
      3:       m_op = OP_ROWS[3 + v][f3];
      4:       m_op = OP_ROWS[6 + v][f3];
      5:       m_op = OP_ROWS[(v == 1) ? 10 : 9][f3];
      6:       m_op = OP_ROWS[11 + v][f3];
      7:       m_op = rv_pkg::OP_LUI;
      8:       m_op = rv_pkg::OP_AUIPC;
      9:       m_op = rv_pkg::OP_JAL;
      default: m_op = (f3 == 3'b000) ? rv_pkg::OP_JALR : rv_pkg::OP_NONE;
    endcase
  end
  legal      = (m_op != rv_pkg::OP_NONE);
  m_rs1_re   = legal && !(cls == 7 || cls == 8 || cls == 9);
  m_rs2_re   = legal && cls >= 1 && cls <= 4;
  m_rd_we    = legal && cls != 1 && cls != 2 && inst[11:7] != 5'd0;
  m_rs1      = m_rs1_re ? inst[19:15] : 5'd0;
  m_rs2      = m_rs2_re ? inst[24:20] : 5'd0;
  m_rd       = m_rd_we ? inst[11:7] : 5'd0;
  m_op1_alt  = (legal && (cls == 8 || cls == 9)) ? pc : '0;
  m_op2_alt  = '0;
  m_mem_off  = '0;
  m_mem_size = '0;
  if (legal) begin
    case (cls)
      0: begin
        m_mem_off  = inst[31:20];
        m_mem_size = f3;
      end
      1: begin
        m_mem_off  = {inst[31:25], inst[11:7]};
        m_mem_size = f3;
      end
      5, 6:    m_op2_alt = {{52{inst[31]}}, inst[31:20]};
      7, 8:    m_op2_alt = {{44{inst[31]}}, inst[31:12]};
      9, 10:   m_op2_alt = pc;
      default: m_op2_alt = '0;
    endcase
  end
endtask

`endif

//--- bench/tb_id_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_id_stage
// random decode, forwarding and stall
// checks of the id stage against a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;

  localparam int NUM_TESTS  = 2000;
  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 8;

  logic              clk = 1'b0;
  logic              rst_i;
  logic              valid_i;
  rv_pkg::inst_t     inst_i;
  rv_pkg::data_t     pc_i;
  rv_pkg::reg_addr_t rs1_addr_o;
  rv_pkg::reg_addr_t rs2_addr_o;
  rv_pkg::data_t     rs1_data_i;
  rv_pkg::data_t     rs2_data_i;
  logic              ex_rd_we_i;
  rv_pkg::reg_addr_t ex_rd_addr_i;
  rv_pkg::data_t     ex_rd_data_i;
  logic              ex_is_load_i;
  logic              mem_rd_we_i;
  rv_pkg::reg_addr_t mem_rd_addr_i;
  rv_pkg::data_t     mem_rd_data_i;
  logic              stall_o;
  logic              ex_valid_o;
  rv_pkg::op_e       ex_op_o;
  rv_pkg::data_t     ex_op1_o;
  rv_pkg::data_t     ex_op2_o;
  rv_pkg::data_t     ex_pc_o;
  logic              ex_rd_we_o;
  rv_pkg::reg_addr_t ex_rd_addr_o;
  rv_pkg::imm12_t    ex_mem_off_o;
  rv_pkg::funct3_t   ex_mem_size_o;

  // prediction for the next ex bundle
  logic              e_valid;
  rv_pkg::op_e       e_op;
  rv_pkg::data_t     e_op1;
  rv_pkg::data_t     e_op2;
  rv_pkg::data_t     e_pc;
  logic              e_rd_we;
  rv_pkg::reg_addr_t e_rd;
  rv_pkg::imm12_t    e_off;
  rv_pkg::funct3_t   e_size;
  int                errors = 0;
  int                test_no = 0;

  `include "id_model.svh"

  id_stage uut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_op(input string name, input rv_pkg::op_e exp, input rv_pkg::op_e act);
    if (act !== exp) begin
      $display("mismatch %s[%0d] expected %0d actual %0d", name, test_no, exp, act);
      errors++;
    end
  endtask

  task automatic check_data(input string name, input rv_pkg::data_t exp,
                            input rv_pkg::data_t act);
    if (act !== exp) begin
      $display("mismatch %s[%0d] expected %h actual %h", name, test_no, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input rv_pkg::reg_addr_t exp,
                            input rv_pkg::reg_addr_t act);
    if (act !== exp) begin
      $display("mismatch %s[%0d] expected %0d actual %0d", name, test_no, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s[%0d] expected %b actual %b", name, test_no, exp, act);
      errors++;
    end
  endtask

  task automatic check_off(input string name, input rv_pkg::imm12_t exp,
                           input rv_pkg::imm12_t act);
    if (act !== exp) begin
      $display("mismatch %s[%0d] expected %h actual %h", name, test_no, exp, act);
      errors++;
    end
  endtask

  task automatic check_bundle();
    check_bit("ex_valid", e_valid, ex_valid_o);
    check_op("ex_op", e_op, ex_op_o);
    check_data("ex_op1", e_op1, ex_op1_o);
    check_data("ex_op2", e_op2, ex_op2_o);
    check_data("ex_pc", e_pc, ex_pc_o);
    check_bit("ex_rd_we", e_rd_we, ex_rd_we_o);
    check_addr("ex_rd_addr", e_rd, ex_rd_addr_o);
    check_off("ex_mem_off", e_off, ex_mem_off_o);
    check_off("ex_mem_size", {9'd0, e_size}, {9'd0, ex_mem_size_o});
  endtask

  // sources of the current word, x0, or anything
  function automatic rv_pkg::reg_addr_t pick_fwd_addr(input logic [1:0] sel);
    logic [31:0] x;
    x = xorshift32();
    case (sel)
      2'd0:    return inst_i[19:15];
      2'd1:    return inst_i[24:20];
      2'd2:    return 5'd0;
      default: return x[4:0];
    endcase
  endfunction

  // youngest write wins over the register file
  function automatic rv_pkg::data_t expect_operand(input logic re, input rv_pkg::reg_addr_t a,
                                                   input rv_pkg::data_t rf,
                                                   input rv_pkg::data_t alt);
    rv_pkg::data_t v;
    v = alt;
    if (re) begin
      v = (ex_rd_we_i && ex_rd_addr_i == a) ? ex_rd_data_i :
          (mem_rd_we_i && mem_rd_addr_i == a) ? mem_rd_data_i : rf;
    end
    return v;
  endfunction

  initial begin
    #(NUM_TESTS * CLK_PERIOD * 2 + (RST_CYCLES + 2) * CLK_PERIOD);
    $display("timeout: the stimulus loop did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0]       r;
    logic              re1;
    logic              re2;
    logic              exp_stall;
    logic              held;
    logic              prev_we;
    rv_pkg::reg_addr_t prev_addr;
    rst_i = 1'b1;
    // addi x1, x0, 1 stays valid through reset
    valid_i = 1'b1;
    inst_i = 32'h0010_0093;
    pc_i = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    ex_rd_we_i = 1'b0;
    ex_rd_addr_i = '0;
    ex_rd_data_i = '0;
    ex_is_load_i = 1'b0;
    mem_rd_we_i = 1'b0;
    mem_rd_addr_i = '0;
    mem_rd_data_i = '0;
    held = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    check_bit("reset ex_valid", 1'b0, ex_valid_o);
    check_bit("reset ex_rd_we", 1'b0, ex_rd_we_o);
    check_op("reset ex_op", rv_pkg::OP_NONE, ex_op_o);
    for (int n = 0; n < NUM_TESTS; n++) begin
      if (n > 0) begin
        @(negedge clk);
        check_bundle();
      end
      test_no = n;
      r = xorshift32();
      prev_we = ex_rd_we_i;
      prev_addr = ex_rd_addr_i;
      // a stalled word is held and its load moves on to mem
      if (!held) begin
        valid_i = (r[6:4] != 3'd0);
        pc_i = {xorshift32(), xorshift32()};
        build_inst(pc_i, inst_i);
        ex_rd_addr_i = pick_fwd_addr(r[9:8]);
        ex_rd_we_i = r[0] && (ex_rd_addr_i != 5'd0);
        ex_is_load_i = r[2];
        mem_rd_addr_i = pick_fwd_addr(r[11:10]);
        mem_rd_we_i = r[1] && (mem_rd_addr_i != 5'd0);
      end else begin
        ex_rd_addr_i = 5'd0;
        ex_rd_we_i = 1'b0;
        ex_is_load_i = 1'b0;
        mem_rd_addr_i = prev_addr;
        mem_rd_we_i = prev_we;
      end
      rs1_data_i = {xorshift32(), xorshift32()};
      rs2_data_i = {xorshift32(), xorshift32()};
      ex_rd_data_i = {xorshift32(), xorshift32()};
      mem_rd_data_i = {xorshift32(), xorshift32()};
      #1;
      re1 = valid_i && m_rs1_re;
      re2 = valid_i && m_rs2_re;
      exp_stall = ex_is_load_i && ((re1 && m_rs1 == ex_rd_addr_i) ||
                                   (re2 && m_rs2 == ex_rd_addr_i));
      check_addr("rs1_addr", re1 ? m_rs1 : 5'd0, rs1_addr_o);
      check_addr("rs2_addr", re2 ? m_rs2 : 5'd0, rs2_addr_o);
      check_bit("stall", exp_stall, stall_o);
      e_valid = valid_i && !exp_stall;
      e_op = e_valid ? m_op : rv_pkg::OP_NONE;
      e_op1 = e_valid ? expect_operand(re1, m_rs1, rs1_data_i, m_op1_alt) : '0;
      e_op2 = e_valid ? expect_operand(re2, m_rs2, rs2_data_i, m_op2_alt) : '0;
      e_pc = e_valid ? pc_i : '0;
      e_rd_we = e_valid && m_rd_we;
      e_rd = e_valid ? m_rd : 5'd0;
      e_off = e_valid ? m_mem_off : 12'd0;
      e_size = e_valid ? m_mem_size : 3'd0;
      held = exp_stall;
    end
    @(negedge clk);
    check_bundle();
    $display("errors %0d in %0d tests", errors, NUM_TESTS);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+bench
logic/rv_pkg.sv
logic/inst_decoder.sv
logic/operand_bypass.sv
logic/id_ex_reg.sv
logic/id_stage.sv
bench/tb_id_stage.sv

//--- run.sh
#!/usr/bin/env bash
# build the id stage testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_id_stage -f tb.f \
  && ./obj_dir/Vtb_id_stage | tee /dev/stderr | grep -q "^TESTS PASSED$" \
  && exit 0 \
  || exit 1
